//--- sources.f
+incdir+src
src/multCtrlPkg.sv
src/multDataPkg.sv
src/inputSynchronizer.sv
src/multiplierController.sv
src/addSubUnit.sv
src/operandRegisters.sv
src/multiplierTop.sv
sim/multiplierTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the multiplier testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module multiplierTb -o multiplierTb > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/multiplierTb > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- sim/multiplierTb.sv
// Directed-test testbench for the signed multiplier; compile with sources.f, top is multiplierTb.
`timescale 1ns/100ps
`include "mult_macros.svh"

module multiplierTb;

	localparam int ProductWidth  = `PRODUCT_WIDTH;
	localparam int NumMultiplies = 50; // Reset 1, corner 5, random 40, chained 2, held 1, clear/load 1.
	localparam int CycleLimit    = 60 * NumMultiplies;
	localparam int DoneWaitLimit = `SYNC_STAGES + 2 * `SHIFT_STEPS + 8;

	logic                    Clk = 1'b0;
	logic                    reset;
	logic                    Run;
	logic                    ClearA_LoadB;
	multDataPkg::operand     Switches;
	multDataPkg::operand     Aval;
	multDataPkg::operand     Bval;
	logic                    X;
	logic                    Done;
	multDataPkg::productWord Product;

	logic [31:0] lfsrState   = 32'hd011_bfed;
	int          valueErrors = 0;
	int          otherErrors = 0;
	int          cycleCount  = 0;

	multiplierTop i_multiplierTop (
		.Clk          (Clk),
		.reset        (reset),
		.Run          (Run),
		.ClearA_LoadB (ClearA_LoadB),
		.Switches     (Switches),
		.Aval         (Aval),
		.Bval         (Bval),
		.X            (X),
		.Done         (Done),
		.Product      (Product)
	);

	always #4 Clk = ~Clk;

	always @(posedge Clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit)
		begin
			$display("Timeout: tests did not finish within %0d cycles", CycleLimit);
			$display("Errors: %0d value, %0d other", valueErrors, otherErrors);
			$display("** FAIL **");
			$finish;
		end
	end

	// --------------------------------------------------
	// Stimulus helpers
	// --------------------------------------------------
	// Taps at x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic takeRandomOperand(output multDataPkg::operand value);
		value = '0;
		repeat (`MULT_WIDTH)
		begin
			lfsrState = lfsrNext(lfsrState);
			value     = {value[`MULT_WIDTH-2:0], lfsrState[0]}; // One step per bit.
		end
	endtask

	function automatic multDataPkg::productWord expectedProduct(input multDataPkg::operand s, b);
		multDataPkg::productWord p;
		p.full = ProductWidth'(s) * ProductWidth'(b); // Signed operands sign-extend.
		return p;
	endfunction

	task automatic applyReset();
		reset        <= 1'b1;
		Run          <= 1'b0;
		ClearA_LoadB <= 1'b0;
		Switches     <= '0;
		repeat (5) @(posedge Clk);
		reset <= 1'b0;
	endtask

	task automatic loadOperandB(input multDataPkg::operand b);
		@(posedge Clk);
		Switches     <= b;
		ClearA_LoadB <= 1'b1;
		repeat (`SYNC_STAGES + 1) @(posedge Clk);
		ClearA_LoadB <= 1'b0;
		repeat (`SYNC_STAGES + 1) @(posedge Clk); // Let the release pass the synchronizer.
	endtask

	task automatic startRun(input multDataPkg::operand s);
		@(posedge Clk);
		Switches <= s;
		Run      <= 1'b1;
	endtask

	task automatic waitForDone(input string what);
		int waited;
		waited = 0;
		@(negedge Clk);
		while (!Done && waited < DoneWaitLimit)
		begin
			@(negedge Clk);
			waited++;
		end
		if (!Done)
		begin
			otherErrors++;
			$display("Done never rose during %s within %0d cycles (time %0t)", what, waited, $time);
		end
	endtask

	task automatic releaseRun();
		int waited;
		waited = 0;
		@(posedge Clk);
		Run <= 1'b0;
		@(negedge Clk);
		while (Done && waited < DoneWaitLimit)
		begin
			@(negedge Clk);
			waited++;
		end
		if (Done)
		begin
			otherErrors++;
			$display("Done stayed high after Run was released (time %0t)", $time);
		end
	endtask

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	task automatic checkProduct(input multDataPkg::productWord actual, expected,
		input string what);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what,
				actual.full, expected.full);
		end
	endtask

	task automatic checkOperand(input multDataPkg::operand actual, expected, input string what);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic checkFlag(input logic actual, expected, input string what);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic checkResult(input multDataPkg::operand s, b, input string what);
		multDataPkg::productWord expected;
		expected = expectedProduct(s, b);
		checkProduct(Product, expected, what);
		checkOperand(Aval, expected.halves.hi, "Aval");
		checkOperand(Bval, expected.halves.lo, "Bval");
		checkFlag(X, expected.full[ProductWidth-1], "X as product sign");
	endtask

	task automatic multiplyOnce(input multDataPkg::operand s, b, input string what);
		loadOperandB(b);
		startRun(s);
		waitForDone(what);
		checkResult(s, b, what);
		releaseRun();
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic testResetState();
		loadOperandB(8'sh5D);
		startRun(8'sh93);
		waitForDone("setup for reset");
		checkResult(8'sh93, 8'sh5D, "setup for reset"); // A, B and X nonzero, Done held.
		@(posedge Clk);
		reset <= 1'b1;
		repeat (3) @(posedge Clk);
		Run <= 1'b0; // Synchronized Run is low by the time reset falls.
		repeat (2) @(posedge Clk);
		reset <= 1'b0;
		@(negedge Clk);
		checkOperand(Aval, '0, "Aval after reset");
		checkOperand(Bval, '0, "Bval after reset");
		checkFlag(X, 1'b0, "X after reset");
		checkFlag(Done, 1'b0, "Done after reset");
	endtask

	task automatic testCornerCases();
		multiplyOnce(8'sh00, 8'shB3, "0 * -77");
		multiplyOnce(8'sh01, 8'shFF, "1 * -1");
		multiplyOnce(8'sh80, 8'sh80, "-128 * -128");
		multiplyOnce(8'sh7F, 8'sh80, "127 * -128");
		multiplyOnce(8'shFF, 8'shFF, "-1 * -1");
	endtask

	task automatic testRandomPairs();
		multDataPkg::operand s;
		multDataPkg::operand b;
		for (int i = 0; i < 40; i++)
		begin
			takeRandomOperand(s);
			takeRandomOperand(b);
			multiplyOnce(s, b, "random pair");
		end
	endtask

	task automatic testChainedRun();
		multDataPkg::productWord first;
		first = expectedProduct(8'sh25, 8'shE9);
		multiplyOnce(8'sh25, 8'shE9, "first of chained pair");
		startRun(8'sh4C); // B is now the low byte of the last product.
		waitForDone("chained run");
		checkResult(8'sh4C, first.halves.lo, "chained run");
		releaseRun();
	endtask

	task automatic testHeldRunAndLoadPulse();
		multDataPkg::productWord expected;
		expected = expectedProduct(8'sh6B, 8'shFF);
		loadOperandB(8'shFF); // All ones gives the longest run.
		startRun(8'sh6B);
		repeat (`SYNC_STAGES + 1) @(posedge Clk);
		ClearA_LoadB <= 1'b1;
		repeat (2) @(posedge Clk);
		ClearA_LoadB <= 1'b0;
		waitForDone("run with load pulse");
		checkResult(8'sh6B, 8'shFF, "run with load pulse");
		repeat (10)
		begin
			@(negedge Clk);
			checkFlag(Done, 1'b1, "Done with Run held");
			checkProduct(Product, expected, "product with Run held");
		end
		releaseRun();
	endtask

	task automatic testClearLoad();
		multiplyOnce(8'shFB, 8'sh07, "setup for clear and load"); // Leaves A and X nonzero.
		loadOperandB(8'sh5A);
		@(negedge Clk);
		checkOperand(Aval, '0, "Aval after clear and load");
		checkFlag(X, 1'b0, "X after clear and load");
		checkOperand(Bval, Switches, "Bval after clear and load");
		checkOperand(Bval, 8'sh5A, "Bval loaded value");
	endtask

	initial
	begin
		applyReset();
		testResetState();
		testCornerCases();
		testRandomPairs();
		testChainedRun();
		testHeldRunAndLoadPulse();
		testClearLoad();
		$display("Errors: %0d value, %0d other", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- src/multiplierTop.sv
// Top level of the signed multiplier; switches in, A, B, X and the product out.
`timescale 1ns/100ps
`include "mult_macros.svh"

module multiplierTop (
	input  logic                    Clk,
	input  logic                    reset,
	input  logic                    Run,
	input  logic                    ClearA_LoadB,
	input  multDataPkg::operand     Switches,
	output multDataPkg::operand     Aval,
	output multDataPkg::operand     Bval,
	output logic                    X,
	output logic                    Done,
	output multDataPkg::productWord Product
);

	logic                    runSync;
	logic                    clearLoadSync;
	multDataPkg::operand     S;
	multCtrlPkg::ctrlWord    ctrl;
	multDataPkg::sumWord     sum;
	multDataPkg::productWord product;
	logic                    M;

	// --------------------------------------------------
	// Inputs
	// --------------------------------------------------
	inputSynchronizer #(
		.Width(`MULT_WIDTH + 2)
	) i_inputSynchronizer (
		.Clk     (Clk),
		.asyncIn ({Run, ClearA_LoadB, Switches}),
		.syncOut ({runSync, clearLoadSync, S})
	);

	multiplierController i_multiplierController (
		.Clk          (Clk),
		.reset        (reset),
		.Run          (runSync),
		.ClearA_LoadB (clearLoadSync),
		.M            (M),
		.ctrl         (ctrl),
		.Done         (Done)
	);

	// --------------------------------------------------
	// Datapath
	// --------------------------------------------------
	addSubUnit i_addSubUnit (
		.A   (product.halves.hi),
		.S   (S),
		.sub (ctrl.sub),
		.sum (sum)
	);

	operandRegisters i_operandRegisters (
		.Clk     (Clk),
		.reset   (reset),
		.ctrl    (ctrl),
		.S       (S),
		.sum     (sum),
		.X       (X),
		.product (product),
		.M       (M)
	);

	assign Aval    = product.halves.hi;
	assign Bval    = product.halves.lo;
	assign Product = product;

endmodule

//--- src/operandRegisters.sv
// X, A and B registers of the multiplier with clear/load, add writeback and arithmetic shift.
`timescale 1ns/100ps
`include "mult_macros.svh"

module operandRegisters (
	input  logic                    Clk,
	input  logic                    reset,
	input  multCtrlPkg::ctrlWord    ctrl,
	input  multDataPkg::operand     S,
	input  multDataPkg::sumWord     sum,
	output logic                    X,
	output multDataPkg::productWord product,
	output logic                    M
);

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			X            <= 1'b0;
			product.full <= '0;
		end
		else if (ctrl.clrLd)
		begin
			X                 <= 1'b0;
			product.halves.hi <= '0;
			if (!ctrl.shift)
				product.halves.lo <= S; // Start of a multiply keeps B.
		end
		else if (ctrl.add || ctrl.sub)
		begin
			X                 <= sum.signBit;
			product.halves.hi <= sum.value;
		end
		else if (ctrl.shift)
		begin
			// X stays put, so it keeps feeding the sign into A.
			product.halves.hi <= {X, product.halves.hi[`MULT_WIDTH-1:1]};
			product.halves.lo <= {product.halves.hi[0], product.halves.lo[`MULT_WIDTH-1:1]};
		end
	end

	// M is bit 0 of B as it will stand after this clock edge.
	always_comb
	begin
		if (ctrl.clrLd && !ctrl.shift)
			M = S[0];
		else if (ctrl.shift && !ctrl.clrLd)
			M = product.halves.lo[1];
		else
			M = product.halves.lo[0];
	end

endmodule

//--- src/addSubUnit.sv
// Nine-bit ripple adder/subtractor that forms the new X and A from A and S.
`timescale 1ns/100ps
`include "mult_macros.svh"

module addSubUnit (
	input  multDataPkg::operand A,
	input  multDataPkg::operand S,
	input  logic                sub,
	output multDataPkg::sumWord sum
);

	logic [`MULT_WIDTH:0] aExt;
	logic [`MULT_WIDTH:0] sExt;
	logic [`MULT_WIDTH:0] total;

	// Sign-extend both operands so the ninth bit carries the true sign.
	assign aExt = {A[`MULT_WIDTH-1], A};
	assign sExt = {S[`MULT_WIDTH-1], S} ^ {(`MULT_WIDTH + 1){sub}}; // Invert for A - S.

	// Full adder chain.
	always_comb
	begin
		logic carry;
		carry = sub; // Completes the two's complement of S.
		for (int i = 0; i <= `MULT_WIDTH; i++)
		begin
			total[i] = aExt[i] ^ sExt[i] ^ carry;
			carry    = (aExt[i] & sExt[i]) | (carry & (aExt[i] ^ sExt[i]));
		end
	end

	assign sum = multDataPkg::sumWord'(total);

endmodule

//--- src/multiplierController.sv
// Multiplier FSM; sequences clear/load, the add or subtract steps and the eight shifts.
`timescale 1ns/100ps
`include "mult_macros.svh"

module multiplierController (
	input  logic                  Clk,
	input  logic                  reset,
	input  logic                  Run,
	input  logic                  ClearA_LoadB,
	input  logic                  M,
	output multCtrlPkg::ctrlWord  ctrl,
	output logic                  Done
);

	// Final shift state; the add step that returns here handles the sign bit.
	localparam multCtrlPkg::ctrlState LastShift =
		multCtrlPkg::ctrlState'(multCtrlPkg::Shift0 + `SHIFT_STEPS - 1);

	multCtrlPkg::ctrlState state;
	multCtrlPkg::ctrlState nextState;
	multCtrlPkg::ctrlState returnState; // Shift state to resume after AddStep.
	multCtrlPkg::ctrlState afterAdd;

	// --------------------------------------------------
	// State registers
	// --------------------------------------------------
	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			state       <= multCtrlPkg::Wait;
			returnState <= multCtrlPkg::Wait;
		end
		else
		begin
			state <= nextState;
			if (nextState == multCtrlPkg::AddStep)
				returnState <= afterAdd;
		end
	end

	// --------------------------------------------------
	// Next state
	// --------------------------------------------------
	always_comb
	begin
		nextState = state;
		afterAdd  = returnState;
		case (state)
			multCtrlPkg::Wait:
			begin
				if (Run)
				begin
					afterAdd  = multCtrlPkg::Shift0;
					nextState = M ? multCtrlPkg::AddStep : multCtrlPkg::Shift0;
				end
			end
			LastShift:
				nextState = multCtrlPkg::Done;
			multCtrlPkg::Done:
			begin
				if (!Run)
					nextState = multCtrlPkg::Wait; // Hold here so one press runs once.
			end
			multCtrlPkg::AddStep:
				nextState = returnState;
			default:
			begin
				// Shift0 up to the one before LastShift look at the next multiplier bit.
				if (state >= multCtrlPkg::Shift0 && state < LastShift)
				begin
					afterAdd  = multCtrlPkg::ctrlState'(state + 1);
					nextState = M ? multCtrlPkg::AddStep : afterAdd;
				end
				else
					nextState = multCtrlPkg::Wait;
			end
		endcase
	end

	// --------------------------------------------------
	// Control outputs
	// --------------------------------------------------
	always_comb
	begin
		ctrl = '0;
		case (state)
			multCtrlPkg::Wait:
			begin
				ctrl.clrLd = ClearA_LoadB | Run;
				ctrl.shift = Run & ~ClearA_LoadB; // Clear A and X but keep B.
			end
			multCtrlPkg::AddStep:
			begin
				ctrl.sub = (returnState == LastShift); // Sign bit weighs negative.
				ctrl.add = (returnState != LastShift);
			end
			multCtrlPkg::Done:
				ctrl = '0;
			default:
				ctrl.shift = 1'b1;
		endcase
	end

	assign Done = (state == multCtrlPkg::Done);

endmodule

//--- src/inputSynchronizer.sv
// Flip-flop chains that bring the raw switches and buttons into the Clk domain.
`timescale 1ns/100ps
`include "mult_macros.svh"

module inputSynchronizer #(
	parameter int Width = 1
) (
	input  logic             Clk,
	input  logic [Width-1:0] asyncIn,
	output logic [Width-1:0] syncOut
);

	// Stage 0 samples the pins, the last stage feeds the design.
	logic [`SYNC_STAGES-1:0][Width-1:0] chain;

	always_ff @(posedge Clk)
	begin
		chain <= {chain[`SYNC_STAGES-2:0], asyncIn};
	end

	assign syncOut = chain[`SYNC_STAGES-1];

endmodule

//--- src/multDataPkg.sv
// Datapath types for the multiplier: operands, adder result and the A:B product register.
`include "mult_macros.svh"

package multDataPkg;

	// Two's complement operand, used for S, A and B.
	typedef logic signed [`MULT_WIDTH-1:0] operand;

	// Adder output, nine bits wide.
	typedef struct packed {
		logic   signBit; // Becomes X.
		operand value;   // Becomes A.
	} sumWord;

	// --------------------------------------------------
	// Product register
	// --------------------------------------------------
	// The register pair as the shifter sees it.
	typedef struct packed {
		operand hi; // Register A.
		operand lo; // Register B.
	} productHalves;

	// Same 16 bits read either as one signed product or as the A and B halves.
	typedef union packed {
		logic signed [`PRODUCT_WIDTH-1:0] full;
		productHalves halves;
	} productWord;

endpackage

//--- src/multCtrlPkg.sv
// Controller types shared by the multiplier FSM and the datapath it drives.
`include "mult_macros.svh"

package multCtrlPkg;

	// --------------------------------------------------
	// FSM states
	// --------------------------------------------------
	// Shift states are consecutive so the FSM can step through them by adding one.
	typedef enum logic [$clog2(`SHIFT_STEPS + 3)-1:0] {
		Wait    = 4'd0,
		Shift0  = 4'd1,
		Shift1  = 4'd2,
		Shift2  = 4'd3,
		Shift3  = 4'd4,
		Shift4  = 4'd5,
		Shift5  = 4'd6,
		Shift6  = 4'd7,
		Shift7  = 4'd8,
		Done    = 4'd9,
		AddStep = 4'd10
	} ctrlState;

	// --------------------------------------------------
	// Datapath control word
	// --------------------------------------------------
	// clrLd alone clears X and A and loads B from S.
	// clrLd with shift clears X and A but keeps B, which starts a multiply.
	typedef struct packed {
		logic clrLd;
		logic shift; // Arithmetic right shift of X:A:B.
		logic add;   // X:A <= A + S.
		logic sub;   // X:A <= A - S.
	} ctrlWord;

endpackage

//--- src/mult_macros.svh
// Width and step-count settings for the shift-and-add multiplier; include where sizes are needed.
`ifndef MULT_MACROS_SVH
`define MULT_MACROS_SVH

// --------------------------------------------------
// Operand sizing
// --------------------------------------------------

// Width of S, A and B.
`define MULT_WIDTH 8

// Product is A:B, twice the operand width.
`define PRODUCT_WIDTH (2 * `MULT_WIDTH)

// --------------------------------------------------
// Sequencing
// --------------------------------------------------

// Flip-flops per synchronized switch or button.
`define SYNC_STAGES 2

// One shift state per multiplier bit.
`define SHIFT_STEPS `MULT_WIDTH

`endif
